// ==== obj_pkg.sv ====
//##########################################################################
// shared constants and bus structs for the object table copy path.
// the raster is shrunk for simulation: 32 slots, 24 lines, 16 active.
// one table holds 32 sixteen-bit words; two tables live in memory.
// counters are CNT_W bits wide, so H_TOTAL and V_TOTAL must stay <= 32.
//##########################################################################

package obj_pkg;

    // raster geometry.
    localparam int H_TOTAL   = 32;
    localparam int V_TOTAL   = 24;
    localparam int V_ACTIVE  = 16;
    localparam int COPY_LINE = 16;
    localparam int CNT_W     = 5;

    // object table geometry.
    localparam int OBJ_WORDS = 32;
    localparam int OBJ_AW    = 5;
    localparam int OBJ_DW    = 16;

    // bus side.
    localparam int AXI_AW    = 32;

    // word stored when the slave answers with an error.
    localparam logic [OBJ_DW-1:0] OBJ_BLANK = 16'h0000;

    // raster state, refreshed every clock.
    typedef struct packed {
        logic [CNT_W-1:0] vdump;
        logic [CNT_W-1:0] hdump;
        logic             lvbl;
        logic             pxl_cen;
    } raster_t;

    // word request, address is {table, index}.
    typedef struct packed {
        logic            valid;
        logic [OBJ_AW:0] addr;
    } ord_req_t;

    // word response, valid is a single-cycle pulse.
    typedef struct packed {
        logic              valid;
        logic [OBJ_DW-1:0] data;
        logic              err;
    } ord_rsp_t;

    // frame buffer write port.
    typedef struct packed {
        logic              we;
        logic              bank;
        logic [OBJ_AW-1:0] addr;
        logic [OBJ_DW-1:0] data;
    } fb_wr_t;

endpackage

// ==== raster_timing.sv ====
//##########################################################################
// raster timing: pixel enable on every second clock, line and frame
// counters, and vertical blanking from the line count.
// after reset both counters are 0 and the pixel enable is low.
//##########################################################################
`timescale 1ns/1ns

module raster_timing (
    input  logic             clk,
    input  logic             rst,
    output obj_pkg::raster_t raster
);
    import obj_pkg::*;

    // last slot and last line, sized to the counters.
    localparam logic [CNT_W-1:0] H_LAST = CNT_W'(H_TOTAL - 1);
    localparam logic [CNT_W-1:0] V_LAST = CNT_W'(V_TOTAL - 1);
    localparam logic [CNT_W-1:0] V_ACT  = CNT_W'(V_ACTIVE);

    logic             cen;
    logic [CNT_W-1:0] hcnt;
    logic [CNT_W-1:0] vcnt;

    //######################################################################
    // pixel enable
    //######################################################################

    // toggles each clock, so it is high one clock in two.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen <= 1'b0;
        end else begin
            cen <= ~cen;
        end
    end

    //######################################################################
    // line and frame counters
    //######################################################################

    // hdump moves on the pixel enable, vdump on the hdump wrap.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (cen) begin
            if (hcnt == H_LAST) begin
                hcnt <= '0;
                // end of line, step the line count.
                if (vcnt == V_LAST) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // blanking follows the line count directly.
    assign raster.vdump   = vcnt;
    assign raster.hdump   = hcnt;
    assign raster.lvbl    = vcnt < V_ACT;
    assign raster.pxl_cen = cen;

endmodule

// ==== obj_frame_copy.sv ====
//##########################################################################
// frame copier: once per frame, from line COPY_LINE on, reads the 32
// table words one at a time and writes them to the hidden bank.
// the source table is sampled at copy start. banks swap on line 0; a
// copy still running then is cut short and copy_overrun stays set.
//##########################################################################
`timescale 1ns/1ns

module obj_frame_copy (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::raster_t  raster,
    input  logic              obank,
    input  obj_pkg::ord_rsp_t rsp,
    output obj_pkg::ord_req_t req,
    output obj_pkg::fb_wr_t   fb_wr,
    output logic              frame_bank,
    output logic              copy_overrun
);
    import obj_pkg::*;

    localparam logic [CNT_W-1:0]  START_LINE = CNT_W'(COPY_LINE);
    localparam logic [OBJ_AW-1:0] LAST_IDX   = OBJ_AW'(OBJ_WORDS - 1);

    logic              frame, frame_q, frame_edge;
    logic              start, start_q, start_edge;
    logic              busy;
    logic              stale;
    logic              src_bank;
    logic              take;
    logic [OBJ_AW-1:0] idx;
    logic              wr_we;
    logic              wr_bank;
    logic [OBJ_AW-1:0] wr_addr;
    logic [OBJ_DW-1:0] wr_data;

    //######################################################################
    // frame and copy-start edges
    //######################################################################

    assign frame      = raster.vdump == '0;
    assign frame_edge = frame & ~frame_q;
    assign start      = raster.vdump == START_LINE;
    assign start_edge = start & ~start_q;

    // frame_q starts high, the counters come out of reset on line 0.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_q    <= 1'b1;
            start_q    <= 1'b0;
            frame_bank <= 1'b0;
        end else begin
            frame_q <= frame;
            start_q <= start;
            if (frame_edge) begin
                frame_bank <= ~frame_bank;
            end
        end
    end

    //######################################################################
    // copy sequencer
    //######################################################################

    // a response counts only for a live copy, and never on the swap cycle.
    assign take = rsp.valid & busy & ~stale & ~frame_edge;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            idx          <= '0;
            src_bank     <= 1'b0;
            copy_overrun <= 1'b0;
        end else if (frame_edge && busy) begin
            // swap came first, drop what is left.
            busy         <= 1'b0;
            copy_overrun <= 1'b1;
        end else if (start_edge) begin
            busy     <= 1'b1;
            idx      <= '0;
            src_bank <= obank;
        end else if (take) begin
            idx <= idx + 1'b1;
            if (idx == LAST_IDX) begin
                busy <= 1'b0;
            end
        end
    end

    // an aborted copy leaves one read in flight in the master.
    // its answer is swallowed before the next request goes out.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stale <= 1'b0;
        end else if (rsp.valid && stale) begin
            stale <= 1'b0;
        end else if (frame_edge && busy && !rsp.valid) begin
            stale <= 1'b1;
        end
    end

    // held until the response pulse moves idx on.
    assign req.valid = busy & ~stale;
    assign req.addr  = {src_bank, idx};

    //######################################################################
    // frame buffer write, one clock after the response
    //######################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_we <= 1'b0;
        end else begin
            wr_we <= take;
        end
    end

    // error words are stored blank.
    always_ff @(posedge clk) begin
        if (take) begin
            wr_bank <= ~frame_bank;
            wr_addr <= idx;
            wr_data <= rsp.err ? OBJ_BLANK : rsp.data;
        end
    end

    assign fb_wr.we   = wr_we;
    assign fb_wr.bank = wr_bank;
    assign fb_wr.addr = wr_addr;
    assign fb_wr.data = wr_data;

endmodule

// ==== axil_read_master.sv ====
//##########################################################################
// AXI4-Lite read master for single words. one request in flight.
// the byte address is the word address times 4, zero-extended.
// only the low 16 bits of rdata are kept; any nonzero rresp flags err.
// the response pulse is the R handshake cycle itself.
//##########################################################################
`timescale 1ns/1ns

module axil_read_master (
    input  logic                       clk,
    input  logic                       rst,
    input  obj_pkg::ord_req_t          req,
    output obj_pkg::ord_rsp_t          rsp,
    output logic [obj_pkg::AXI_AW-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [31:0]                rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t state;

    //######################################################################
    // transaction FSM
    //######################################################################

    // idle takes a request, addr waits for arready, data waits for rvalid.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req.valid) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address is latched once, so it holds steady while stalled.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req.valid) begin
            araddr <= AXI_AW'({req.addr, 2'b00});
        end
    end

    assign arvalid = state == ST_ADDR;
    assign rready  = state == ST_DATA;

    // the copier sees the data on the R handshake.
    assign rsp.valid = (state == ST_DATA) && rvalid;
    assign rsp.data  = rdata[OBJ_DW-1:0];
    assign rsp.err   = rresp != 2'b00;

endmodule

// ==== obj_frame_buf.sv ====
//##########################################################################
// double-buffered object memory, 2 banks of 32 words.
// the write port serves the copier on the hidden bank.
// the read port shows the displayed bank one clock after rd_addr.
// no reset, contents are unknown until the first copy lands.
//##########################################################################
`timescale 1ns/1ns

module obj_frame_buf (
    input  logic                       clk,
    input  obj_pkg::fb_wr_t            fb_wr,
    input  logic                       frame_bank,
    input  logic [obj_pkg::OBJ_AW-1:0] rd_addr,
    output logic [obj_pkg::OBJ_DW-1:0] rd_data
);
    import obj_pkg::*;

    localparam int DEPTH = 2 * OBJ_WORDS;

    // word address is {bank, index}.
    logic [OBJ_DW-1:0] mem [0:DEPTH-1];

    //######################################################################
    // write port, copier side
    //######################################################################

    always_ff @(posedge clk) begin
        if (fb_wr.we) begin
            mem[{fb_wr.bank, fb_wr.addr}] <= fb_wr.data;
        end
    end

    //######################################################################
    // read port, display side
    //######################################################################

    // bank select follows frame_bank, so the swap is seen at once.
    always_ff @(posedge clk) begin
        rd_data <= mem[{frame_bank, rd_addr}];
    end

endmodule

// ==== obj_dma_top.sv ====
//##########################################################################
// object table copy path: raster timing, frame copier, AXI4-Lite read
// master and the double-buffered object memory.
// read-only on the bus, the AW, W and B channels are not present.
// obank picks the source table and is sampled when a copy starts.
//##########################################################################
`timescale 1ns/1ns

module obj_dma_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       obank,
    // display side read port.
    input  logic [obj_pkg::OBJ_AW-1:0] rd_addr,
    output logic [obj_pkg::OBJ_DW-1:0] rd_data,
    // AXI4-Lite read channels.
    output logic [obj_pkg::AXI_AW-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [31:0]                rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready,
    // status.
    output logic                       frame_bank,
    output logic [obj_pkg::CNT_W-1:0]  vdump,
    output logic                       lvbl,
    output logic                       copy_overrun
);
    import obj_pkg::*;

    raster_t  raster;
    ord_req_t req;
    ord_rsp_t rsp;
    fb_wr_t   fb_wr;

    // line count and blanking for the outside.
    assign vdump = raster.vdump;
    assign lvbl  = raster.lvbl;

    raster_timing u_timing (
        .clk    (clk),
        .rst    (rst),
        .raster (raster)
    );

    obj_frame_copy u_copy (
        .clk          (clk),
        .rst          (rst),
        .raster       (raster),
        .obank        (obank),
        .rsp          (rsp),
        .req          (req),
        .fb_wr        (fb_wr),
        .frame_bank   (frame_bank),
        .copy_overrun (copy_overrun)
    );

    axil_read_master u_rd (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rsp     (rsp),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    obj_frame_buf u_buf (
        .clk        (clk),
        .fb_wr      (fb_wr),
        .frame_bank (frame_bank),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

// ==== tb_axil_mem.sv ====
//##########################################################################
// AXI4-Lite read slave model for the testbench, one read at a time.
// each word reads back as its word address XOR 16'hA5C3 in the low half.
// arready comes ar_delay clocks after arvalid, rvalid r_delay clocks
// after the address handshake. one word address can answer SLVERR.
//##########################################################################
`timescale 1ns/1ns

module tb_axil_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [7:0]  ar_delay,
    input  logic [7:0]  r_delay,
    input  logic        err_en,
    input  logic [5:0]  err_addr
);
    logic [7:0] cnt;
    logic       rd_busy;
    logic [5:0] waddr;

    // address phase, then data phase, both with their own stall count.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= '0;
            cnt     <= '0;
            rd_busy <= 1'b0;
            waddr   <= '0;
        end else begin
            // arready is a one-clock pulse.
            arready <= 1'b0;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                // byte address to word address.
                rd_busy <= 1'b1;
                waddr   <= araddr[7:2];
                cnt     <= '0;
            end else if (arvalid && !rd_busy) begin
                if (cnt >= ar_delay) begin
                    arready <= 1'b1;
                    cnt     <= '0;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end else if (rd_busy && !rvalid) begin
                if (cnt >= r_delay) begin
                    rvalid  <= 1'b1;
                    rd_busy <= 1'b0;
                    cnt     <= '0;
                    rdata   <= {16'h0, {10'h0, waddr} ^ 16'hA5C3};
                    rresp   <= (err_en && waddr == err_addr) ? 2'b10 : 2'b00;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end
        end
    end

endmodule

// ==== tb_obj_dma.sv ====
//##########################################################################
// testbench for the object table copy path.
// the memory model returns word address XOR 16'hA5C3 per word.
// tests run in sequence on the free-running raster.
// one frame is 1536 clocks and every wait gives up after WAIT_MAX clocks.
//##########################################################################
`timescale 1ns/1ns

module tb_obj_dma;
    import obj_pkg::*;

    localparam int          WAIT_MAX   = 4000;
    localparam int          CLK_PERIOD = 40;
    localparam int          FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;
    localparam logic [15:0] PAT_KEY    = 16'hA5C3;

    logic              clk;
    logic              rst;
    logic              obank;
    logic [OBJ_AW-1:0] rd_addr;
    logic [OBJ_DW-1:0] rd_data;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic              frame_bank;
    logic [CNT_W-1:0]  vdump;
    logic              lvbl;
    logic              copy_overrun;

    // memory model controls.
    logic [7:0] ar_delay;
    logic [7:0] r_delay;
    logic       err_en;
    logic [5:0] err_addr;
    logic       slow;

    integer seed;
    int     errors;
    int     tests;
    int     failed;
    string  cur_test;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    obj_dma_top dut (
        .clk (clk), .rst (rst), .obank (obank),
        .rd_addr (rd_addr), .rd_data (rd_data),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .frame_bank (frame_bank), .vdump (vdump), .lvbl (lvbl),
        .copy_overrun (copy_overrun)
    );

    tb_axil_mem mem (
        .clk (clk), .rst (rst),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .ar_delay (ar_delay), .r_delay (r_delay),
        .err_en (err_en), .err_addr (err_addr)
    );

    // fresh latencies after every read.
    // slow mode stretches every data phase to 40 clocks.
    always @(posedge clk) begin
        if (!rst && rvalid && rready) begin
            ar_delay <= 8'($unsigned($random(seed)) % 4);
            r_delay  <= slow ? 8'd40 : 8'($unsigned($random(seed)) % 4);
        end
    end

    //######################################################################
    // reporting and waiting
    //######################################################################

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("[ERROR] in test %s, %s", cur_test, what);
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // returns on the first clock of the given line.
    task automatic wait_line(input int line);
        int n;
        n = 0;
        @(negedge clk);
        while (int'(vdump) == line) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                abort_run($sformatf("the raster to leave line %0d", line));
            end
        end
        n = 0;
        while (int'(vdump) != line) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                abort_run($sformatf("the raster to reach line %0d", line));
            end
        end
    endtask

    // reads all words of the displayed bank.
    // a negative blank_idx marks no word as blank.
    task automatic check_bank(input string name, input logic tbl, input int blank_idx);
        logic [15:0] expected;
        for (int i = 0; i < OBJ_WORDS; i++) begin
            @(posedge clk);
            rd_addr <= OBJ_AW'(i);
            @(posedge clk);
            @(negedge clk);
            if (i == blank_idx) begin
                expected = OBJ_BLANK;
            end else begin
                expected = {10'h0, tbl, 5'(i)} ^ PAT_KEY;
            end
            assert (rd_data == expected)
                else report_mismatch($sformatf("%s word %0d", name, i), expected, rd_data);
        end
    endtask

    task automatic end_test(input int base);
        tests++;
        if (errors == base) begin
            $display("test %-12s ok", cur_test);
        end else begin
            failed++;
            $display("test %-12s failed, %0d errors", cur_test, errors - base);
        end
    endtask

    //######################################################################
    // checks that run all the time
    //######################################################################

    // the address phase holds while the slave stalls.
    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else report_fault("arvalid or araddr changed while arready was low");

    // byte address of a word, zero-extended.
    assert property (@(posedge clk) disable iff (rst)
        arvalid |-> araddr[AXI_AW-1:8] == '0 && araddr[1:0] == 2'b00)
        else report_fault("araddr was not a zero-extended word address");

    // read data is taken as soon as the slave offers it.
    assert property (@(posedge clk) disable iff (rst) rvalid |-> rready)
        else report_fault("rready was low while read data was waiting");

    // one toggle per frame just after the first clock of line 0.
    assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (frame_bank != $past(frame_bank)) ==
                 ($past(vdump) == '0 && $past(vdump, 2) != '0))
        else report_fault("frame_bank did not toggle exactly at the frame edge");

    // overrun is sticky until reset.
    assert property (@(posedge clk) disable iff (rst) copy_overrun |=> copy_overrun)
        else report_fault("copy_overrun cleared without reset");

    // blanking from the line count.
    always @(negedge clk) begin
        if (!rst) begin
            assert (lvbl == (int'(vdump) < V_ACTIVE))
                else report_mismatch("lvbl", int'(vdump) < V_ACTIVE, lvbl);
        end
    end

    //######################################################################
    // test sequence
    //######################################################################

    initial begin
        int  base;
        time t0;
        seed     = 32'hd51b;
        errors   = 0;
        tests    = 0;
        failed   = 0;
        cur_test = "reset";
        rst      = 1'b1;
        obank    = 1'b0;
        rd_addr  = '0;
        ar_delay = 8'd1;
        r_delay  = 8'd2;
        err_en   = 1'b0;
        err_addr = '0;
        slow     = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        base = errors;
        @(negedge clk);
        assert (arvalid == 1'b0) else report_mismatch("reset arvalid", 0, arvalid);
        assert (frame_bank == 1'b0) else report_mismatch("reset frame_bank", 0, frame_bank);
        assert (copy_overrun == 1'b0)
            else report_mismatch("reset copy_overrun", 0, copy_overrun);
        end_test(base);

        // across two frame edges the bank goes 0, 1, 0.
        cur_test = "bank_toggle";
        base = errors;
        wait_line(0);
        t0 = $time;
        wait_line(1);
        assert (frame_bank == 1'b1) else report_mismatch("bank_toggle first", 1, frame_bank);
        wait_line(0);
        // a pixel every second clock sets the frame length.
        assert (int'(($time - t0) / CLK_PERIOD) == FRAME_CLKS)
            else report_mismatch("bank_toggle frame clocks", FRAME_CLKS,
                                 int'(($time - t0) / CLK_PERIOD));
        wait_line(1);
        assert (frame_bank == 1'b0) else report_mismatch("bank_toggle second", 0, frame_bank);
        end_test(base);

        // the last copy ran with obank at 0.
        cur_test = "copy_table0";
        base = errors;
        check_bank(cur_test, 1'b0, -1);
        end_test(base);

        // obank flips back mid-copy and the table must not change.
        cur_test = "copy_table1";
        base = errors;
        @(posedge clk);
        obank <= 1'b1;
        wait_line(COPY_LINE);
        wait_line(COPY_LINE + 1);
        @(posedge clk);
        obank <= 1'b0;
        wait_line(0);
        wait_line(1);
        check_bank(cur_test, 1'b1, -1);
        end_test(base);

        // word 5 of table 0 answers with an error.
        cur_test = "error_word";
        base = errors;
        @(posedge clk);
        err_addr <= 6'd5;
        err_en   <= 1'b1;
        wait_line(0);
        wait_line(1);
        check_bank(cur_test, 1'b0, 5);
        end_test(base);

        // 40 clocks per read cannot fit 32 words in 8 lines.
        cur_test = "overrun";
        base = errors;
        // every copy so far fitted its window.
        assert (copy_overrun == 1'b0) else report_mismatch("overrun clear", 0, copy_overrun);
        @(posedge clk);
        slow <= 1'b1;
        wait_line(0);
        wait_line(1);
        assert (copy_overrun == 1'b1) else report_mismatch("overrun set", 1, copy_overrun);
        wait_line(0);
        wait_line(1);
        assert (copy_overrun == 1'b1) else report_mismatch("overrun held", 1, copy_overrun);
        end_test(base);

        $display("tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== all.f ====
obj_pkg.sv
raster_timing.sv
obj_frame_copy.sv
axil_read_master.sv
obj_frame_buf.sv
obj_dma_top.sv
tb_axil_mem.sv
tb_obj_dma.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_obj_dma \
        -f all.f --Mdir obj_dir -o sim_obj_dma; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_obj_dma 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1
